// File: gt_reset_macros.svh
//--------------------------------------------------------------------------
// Transceiver reset sequencer constants
// Cycle counts for synchronizers, request stretching, settle stalls,
// PLL reset length and CDR lock timeout, all in free-running clock cycles
//--------------------------------------------------------------------------
`ifndef GT_RESET_MACROS_SVH
`define GT_RESET_MACROS_SVH

// Flops in each status synchronizer chain
`define GT_SYNC_DEPTH 2

// Cycles a restart level is held after the last request falls
`define GT_HOLD_CYC 8

// Stall applied by every wait state before it trusts synced status
`define GT_SETTLE_CYC 8

// Minimum time the PLL reset stays asserted
`define GT_PLL_RESET_CYC 16

// Give up on RX CDR lock after this many cycles
`define GT_CDR_TIMEOUT_CYC 200

// Wide enough for every count above
`define GT_TIMER_W 8

`endif

// File: gt_reset_pkg.sv
//--------------------------------------------------------------------------
// Shared types of the transceiver reset sequencer
// Status bundles, reset modes and the three FSM state encodings
//--------------------------------------------------------------------------
package gt_reset_pkg;

  // TX status as seen from the transceiver, synced as one bundle
  typedef struct packed {
    logic plllock;
    logic userclk_active;
    logic resetdone;
  } tx_status_t;

  // RX status adds the CDR lock indicator
  typedef struct packed {
    logic plllock;
    logic cdrlock;
    logic userclk_active;
    logic resetdone;
  } rx_status_t;

  // Entry point of a direction sequencer, PLL reset has priority
  typedef enum logic {
    mode_pll_and_datapath = 1'b0,
    mode_datapath_only    = 1'b1
  } reset_mode_t;

  typedef enum logic [2:0] {
    tx_st_branch, tx_st_pll, tx_st_datapath, tx_st_wait_lock,
    tx_st_wait_userrdy, tx_st_wait_resetdone, tx_st_idle
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_st_branch, rx_st_pll, rx_st_datapath, rx_st_wait_lock,
    rx_st_wait_cdr, rx_st_wait_userrdy, rx_st_wait_resetdone, rx_st_idle
  } rx_state_t;

  typedef enum logic [2:0] {
    all_st_start, all_st_tx_req, all_st_tx_wait,
    all_st_rx_req, all_st_rx_wait, all_st_done
  } all_state_t;

endpackage

// File: status_sync.sv
//--------------------------------------------------------------------------
// Status synchronizer
// Brings a packed bundle of transceiver status bits into the free-running
// clock domain through a short shift chain
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "gt_reset_macros.svh"

module status_sync
  import gt_reset_pkg::*;
#(
  parameter type payload_t = tx_status_t
) (
  input  logic     gtwiz_reset_clk_freerun_in,
  input  payload_t d,
  output payload_t q
);

  // Each bit is a slow level, so syncing the bundle as a whole is safe
  payload_t stage [`GT_SYNC_DEPTH];

  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    stage[0] <= d;
    for (int i = 1; i < `GT_SYNC_DEPTH; i++) begin
      stage[i] <= stage[i-1];
    end
  end

  assign q = stage[`GT_SYNC_DEPTH-1];

endmodule

// File: reset_req_decode.sv
//--------------------------------------------------------------------------
// Reset request decoder for one direction
// Turns PLL and data path requests into a stretched restart level and a
// latched reset mode so the sequencer branches on a stable value
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "gt_reset_macros.svh"

module reset_req_decode
  import gt_reset_pkg::*;
(
  input  logic        gtwiz_reset_clk_freerun_in,
  input  logic        gtwiz_reset_all_sync,
  input  logic        pll_req,
  input  logic        datapath_req,
  output logic        restart,
  output reset_mode_t mode
);

  localparam logic [`GT_TIMER_W-1:0] hold_len = `GT_TIMER_W'(`GT_HOLD_CYC);

  logic                   any_req;
  logic [`GT_TIMER_W-1:0] hold_cnt;

  assign any_req = pll_req | datapath_req;

  // Restart follows any request one cycle later and is held for a few
  // cycles after the last one, which lets short pulses reach the FSM
  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      restart  <= 1'b0;
      hold_cnt <= '0;
    end else if (any_req) begin
      restart  <= 1'b1;
      hold_cnt <= hold_len;
    end else if (hold_cnt != '0) begin
      restart  <= 1'b1;
      hold_cnt <= hold_cnt - 1'b1;
    end else begin
      restart <= 1'b0;
    end
  end

  // A PLL request wins over a data path request anywhere in one window
  // A data path request only sets the mode when no window is open yet
  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      mode <= mode_pll_and_datapath;
    end else if (pll_req) begin
      mode <= mode_pll_and_datapath;
    end else if (datapath_req && !restart) begin
      mode <= mode_datapath_only;
    end
  end

endmodule

// File: reset_all_seq.sv
//--------------------------------------------------------------------------
// Master reset sequencer
// After every system reset, resets the TX PLL and data path first and the
// RX side once the TX side reports done
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "gt_reset_macros.svh"

module reset_all_seq
  import gt_reset_pkg::*;
#(
  parameter int SHARED_PLL = 0
) (
  input  logic gtwiz_reset_clk_freerun_in,
  input  logic gtwiz_reset_all_sync,
  input  logic tx_done,
  input  logic rx_done,
  output logic all_tx_pll_req,
  output logic all_rx_req
);

  localparam logic [`GT_TIMER_W-1:0] settle_last = `GT_TIMER_W'(`GT_SETTLE_CYC - 1);

  all_state_t             state;
  logic [`GT_TIMER_W-1:0] settle_cnt;
  logic                   settled;

  // The done inputs lag the request pulse by a few cycles, so they are
  // only sampled after the settle count runs out
  assign settled = (settle_cnt == settle_last);

  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      state          <= all_st_start;
      settle_cnt     <= '0;
      all_tx_pll_req <= 1'b0;
      all_rx_req     <= 1'b0;
    end else begin
      // Requests are single-cycle pulses
      all_tx_pll_req <= 1'b0;
      all_rx_req     <= 1'b0;
      if (!settled) begin
        settle_cnt <= settle_cnt + 1'b1;
      end
      case (state)
        all_st_start: begin
          state <= all_st_tx_req;
        end
        all_st_tx_req: begin
          all_tx_pll_req <= 1'b1;
          settle_cnt     <= '0;
          state          <= all_st_tx_wait;
        end
        all_st_tx_wait: begin
          if (settled && tx_done) begin
            state <= all_st_rx_req;
          end
        end
        // A shared PLL must still be locked for the RX data path reset
        all_st_rx_req: begin
          if (SHARED_PLL == 0 || tx_done) begin
            all_rx_req <= 1'b1;
            settle_cnt <= '0;
            state      <= all_st_rx_wait;
          end
        end
        all_st_rx_wait: begin
          if (settled && rx_done) begin
            state <= all_st_done;
          end
        end
        all_st_done: begin
          state <= all_st_done;
        end
        default: begin
          state <= all_st_start;
        end
      endcase
    end
  end

endmodule

// File: tx_reset_seq.sv
//--------------------------------------------------------------------------
// Transmitter reset sequencer
// Resets the TX PLL and/or data path, then releases them in order against
// PLL lock, user clock active and reset done
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "gt_reset_macros.svh"

module tx_reset_seq
  import gt_reset_pkg::*;
(
  input  logic        gtwiz_reset_clk_freerun_in,
  input  logic        gtwiz_reset_all_sync,
  input  logic        restart,
  input  reset_mode_t mode,
  input  tx_status_t  status,
  output logic        pllreset_tx,
  output logic        gttxreset,
  output logic        txuserrdy,
  output logic        tx_done
);

  localparam logic [`GT_TIMER_W-1:0] settle_last = `GT_TIMER_W'(`GT_SETTLE_CYC - 1);
  localparam logic [`GT_TIMER_W-1:0] pll_last = `GT_TIMER_W'(`GT_PLL_RESET_CYC - 1);

  tx_state_t              state;
  logic                   restart_q;
  logic [`GT_TIMER_W-1:0] settle_cnt;
  logic [`GT_TIMER_W-1:0] pll_cnt;
  logic                   settled;

  assign settled = (settle_cnt == settle_last);

  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      state       <= tx_st_branch;
      restart_q   <= 1'b0;
      settle_cnt  <= '0;
      pll_cnt     <= '0;
      pllreset_tx <= 1'b1;
      gttxreset   <= 1'b1;
      txuserrdy   <= 1'b0;
      tx_done     <= 1'b0;
    end else begin
      restart_q <= restart;
      // Settle counter saturates, each state change clears it
      if (!settled) begin
        settle_cnt <= settle_cnt + 1'b1;
      end
      if (restart) begin
        state      <= tx_st_branch;
        settle_cnt <= '0;
        pll_cnt    <= '0;
        tx_done    <= 1'b0;
      end else begin
        case (state)
          // Leave only on the falling edge of restart, when mode is final
          tx_st_branch: begin
            if (restart_q) begin
              state <= (mode == mode_pll_and_datapath) ? tx_st_pll : tx_st_datapath;
            end
            settle_cnt <= '0;
            pll_cnt    <= '0;
          end
          tx_st_pll: begin
            pllreset_tx <= 1'b1;
            gttxreset   <= 1'b1;
            txuserrdy   <= 1'b0;
            if (pll_cnt == pll_last) begin
              settle_cnt <= '0;
              state      <= tx_st_wait_lock;
            end else begin
              pll_cnt <= pll_cnt + 1'b1;
            end
          end
          tx_st_datapath: begin
            gttxreset <= 1'b1;
            txuserrdy <= 1'b0;
            if (settled) begin
              settle_cnt <= '0;
              state      <= tx_st_wait_lock;
            end
          end
          // PLL reset goes away here, data path waits for lock
          tx_st_wait_lock: begin
            pllreset_tx <= 1'b0;
            if (settled && status.plllock) begin
              gttxreset  <= 1'b0;
              settle_cnt <= '0;
              state      <= tx_st_wait_userrdy;
            end
          end
          tx_st_wait_userrdy: begin
            if (settled && status.userclk_active) begin
              txuserrdy  <= 1'b1;
              settle_cnt <= '0;
              state      <= tx_st_wait_resetdone;
            end
          end
          tx_st_wait_resetdone: begin
            if (settled && status.resetdone) begin
              tx_done <= 1'b1;
              state   <= tx_st_idle;
            end
          end
          // Losing lock here needs a new request from the user
          tx_st_idle: begin
            if (!status.plllock) begin
              tx_done <= 1'b0;
            end
          end
          default: begin
            tx_done <= 1'b0;
            state   <= tx_st_branch;
          end
        endcase
      end
    end
  end

endmodule

// File: rx_reset_seq.sv
//--------------------------------------------------------------------------
// Receiver reset sequencer
// Like the TX sequencer, plus a wait for CDR lock or its timeout before
// the programmable divider reset is released
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "gt_reset_macros.svh"

module rx_reset_seq
  import gt_reset_pkg::*;
#(
  parameter int SHARED_PLL = 0
) (
  input  logic        gtwiz_reset_clk_freerun_in,
  input  logic        gtwiz_reset_all_sync,
  input  logic        restart,
  input  reset_mode_t mode,
  input  rx_status_t  status,
  output logic        pllreset_rx,
  output logic        rxprogdivreset,
  output logic        gtrxreset,
  output logic        rxuserrdy,
  output logic        rx_done
);

  localparam logic [`GT_TIMER_W-1:0] settle_last = `GT_TIMER_W'(`GT_SETTLE_CYC - 1);
  localparam logic [`GT_TIMER_W-1:0] pll_last = `GT_TIMER_W'(`GT_PLL_RESET_CYC - 1);
  localparam logic [`GT_TIMER_W-1:0] cdr_last = `GT_TIMER_W'(`GT_CDR_TIMEOUT_CYC - 1);

  rx_state_t              state;
  logic                   restart_q;
  logic [`GT_TIMER_W-1:0] settle_cnt;
  logic [`GT_TIMER_W-1:0] pll_cnt;
  logic [`GT_TIMER_W-1:0] cdr_cnt;
  logic                   settled;

  assign settled = (settle_cnt == settle_last);

  always_ff @(posedge gtwiz_reset_clk_freerun_in) begin
    if (gtwiz_reset_all_sync) begin
      state          <= rx_st_branch;
      restart_q      <= 1'b0;
      settle_cnt     <= '0;
      pll_cnt        <= '0;
      cdr_cnt        <= '0;
      // A shared PLL belongs to TX, so RX must not hold it in reset
      pllreset_rx    <= (SHARED_PLL != 0) ? 1'b0 : 1'b1;
      rxprogdivreset <= 1'b1;
      gtrxreset      <= 1'b1;
      rxuserrdy      <= 1'b0;
      rx_done        <= 1'b0;
    end else begin
      restart_q <= restart;
      if (!settled) begin
        settle_cnt <= settle_cnt + 1'b1;
      end
      if (restart) begin
        state      <= rx_st_branch;
        settle_cnt <= '0;
        pll_cnt    <= '0;
        rx_done    <= 1'b0;
      end else begin
        case (state)
          rx_st_branch: begin
            if (restart_q) begin
              state <= (mode == mode_pll_and_datapath) ? rx_st_pll : rx_st_datapath;
            end
            settle_cnt <= '0;
            pll_cnt    <= '0;
          end
          rx_st_pll: begin
            pllreset_rx    <= 1'b1;
            rxprogdivreset <= 1'b1;
            gtrxreset      <= 1'b1;
            rxuserrdy      <= 1'b0;
            if (pll_cnt == pll_last) begin
              settle_cnt <= '0;
              state      <= rx_st_wait_lock;
            end else begin
              pll_cnt <= pll_cnt + 1'b1;
            end
          end
          rx_st_datapath: begin
            rxprogdivreset <= 1'b1;
            gtrxreset      <= 1'b1;
            rxuserrdy      <= 1'b0;
            if (settled) begin
              settle_cnt <= '0;
              state      <= rx_st_wait_lock;
            end
          end
          rx_st_wait_lock: begin
            pllreset_rx <= 1'b0;
            if (settled && status.plllock) begin
              gtrxreset <= 1'b0;
              cdr_cnt   <= '0;
              state     <= rx_st_wait_cdr;
            end
          end
          // Proceed on CDR lock, or assume it is stable after the timeout
          rx_st_wait_cdr: begin
            cdr_cnt <= cdr_cnt + 1'b1;
            if (status.cdrlock || cdr_cnt == cdr_last) begin
              rxprogdivreset <= 1'b0;
              settle_cnt     <= '0;
              state          <= rx_st_wait_userrdy;
            end
          end
          rx_st_wait_userrdy: begin
            if (settled && status.userclk_active) begin
              rxuserrdy  <= 1'b1;
              settle_cnt <= '0;
              state      <= rx_st_wait_resetdone;
            end
          end
          rx_st_wait_resetdone: begin
            if (settled && status.resetdone) begin
              rx_done <= 1'b1;
              state   <= rx_st_idle;
            end
          end
          rx_st_idle: begin
            if (!status.plllock) begin
              rx_done <= 1'b0;
            end
          end
          default: begin
            rx_done <= 1'b0;
            state   <= rx_st_branch;
          end
        endcase
      end
    end
  end

endmodule

// File: gt_reset_top.sv
//--------------------------------------------------------------------------
// Transceiver channel reset sequencer, top level
// Syncs status, merges user and master requests, and runs the TX and RX
// sequencers on the free-running clock
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module gt_reset_top
  import gt_reset_pkg::*;
#(
  parameter int SHARED_PLL = 0
) (
  input  logic gtwiz_reset_clk_freerun_in,
  input  logic gtwiz_reset_all_sync,
  input  logic gtwiz_reset_tx_pll_and_datapath,
  input  logic gtwiz_reset_tx_datapath,
  input  logic gtwiz_reset_rx_pll_and_datapath,
  input  logic gtwiz_reset_rx_datapath,
  input  logic plllock_tx,
  input  logic txresetdone,
  input  logic userclk_tx_active,
  input  logic plllock_rx,
  input  logic rxcdrlock,
  input  logic rxresetdone,
  input  logic userclk_rx_active,
  output logic pllreset_tx,
  output logic gttxreset,
  output logic txuserrdy,
  output logic pllreset_rx,
  output logic rxprogdivreset,
  output logic gtrxreset,
  output logic rxuserrdy,
  output logic reset_tx_done,
  output logic reset_rx_done,
  output logic rx_cdr_stable
);

  tx_status_t  tx_status_raw;
  tx_status_t  tx_status;
  rx_status_t  rx_status_raw;
  rx_status_t  rx_status;
  logic        all_tx_pll_req;
  logic        all_rx_req;
  logic        tx_pll_req;
  logic        rx_pll_req;
  logic        rx_dp_req;
  logic        tx_restart;
  logic        rx_restart;
  reset_mode_t tx_mode;
  reset_mode_t rx_mode;

  //--------------------------------------------------------------------------
  // Status synchronizers
  //--------------------------------------------------------------------------

  assign tx_status_raw = '{plllock: plllock_tx, userclk_active: userclk_tx_active,
                           resetdone: txresetdone};
  assign rx_status_raw = '{plllock: plllock_rx, cdrlock: rxcdrlock,
                           userclk_active: userclk_rx_active, resetdone: rxresetdone};

  status_sync #(.payload_t(tx_status_t)) tx_status_sync (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .d                          (tx_status_raw),
    .q                          (tx_status)
  );

  status_sync #(.payload_t(rx_status_t)) rx_status_sync (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .d                          (rx_status_raw),
    .q                          (rx_status)
  );

  assign rx_cdr_stable = rx_status.cdrlock;

  //--------------------------------------------------------------------------
  // Request merging
  //--------------------------------------------------------------------------

  reset_all_seq #(.SHARED_PLL(SHARED_PLL)) all_seq (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .tx_done                    (reset_tx_done),
    .rx_done                    (reset_rx_done),
    .all_tx_pll_req             (all_tx_pll_req),
    .all_rx_req                 (all_rx_req)
  );

  // With a shared PLL the master only resets the RX data path
  assign tx_pll_req = gtwiz_reset_tx_pll_and_datapath | all_tx_pll_req;
  assign rx_pll_req = gtwiz_reset_rx_pll_and_datapath | (SHARED_PLL == 0 && all_rx_req);
  assign rx_dp_req  = gtwiz_reset_rx_datapath | (SHARED_PLL != 0 && all_rx_req);

  reset_req_decode tx_req_decode (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .pll_req                    (tx_pll_req),
    .datapath_req               (gtwiz_reset_tx_datapath),
    .restart                    (tx_restart),
    .mode                       (tx_mode)
  );

  reset_req_decode rx_req_decode (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .pll_req                    (rx_pll_req),
    .datapath_req               (rx_dp_req),
    .restart                    (rx_restart),
    .mode                       (rx_mode)
  );

  //--------------------------------------------------------------------------
  // Direction sequencers
  //--------------------------------------------------------------------------

  tx_reset_seq tx_seq (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .restart                    (tx_restart),
    .mode                       (tx_mode),
    .status                     (tx_status),
    .pllreset_tx                (pllreset_tx),
    .gttxreset                  (gttxreset),
    .txuserrdy                  (txuserrdy),
    .tx_done                    (reset_tx_done)
  );

  rx_reset_seq #(.SHARED_PLL(SHARED_PLL)) rx_seq (
    .gtwiz_reset_clk_freerun_in (gtwiz_reset_clk_freerun_in),
    .gtwiz_reset_all_sync       (gtwiz_reset_all_sync),
    .restart                    (rx_restart),
    .mode                       (rx_mode),
    .status                     (rx_status),
    .pllreset_rx                (pllreset_rx),
    .rxprogdivreset             (rxprogdivreset),
    .gtrxreset                  (gtrxreset),
    .rxuserrdy                  (rxuserrdy),
    .rx_done                    (reset_rx_done)
  );

endmodule

// File: tb_gt_reset_top.sv
//--------------------------------------------------------------------------
// Testbench for the transceiver channel reset sequencer
// Models PLL lock, CDR lock and reset done around the DUT, then walks a
// table of reset scenarios and checks outputs and event ordering
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "gt_reset_macros.svh"

module tb_gt_reset_top;

  // Request kinds used in the scenario table
  localparam logic [2:0] kind_none     = 3'd0;
  localparam logic [2:0] kind_power_on = 3'd1;
  localparam logic [2:0] kind_tx_dp    = 3'd2;
  localparam logic [2:0] kind_tx_both  = 3'd3;
  localparam logic [2:0] kind_rx_pll   = 3'd4;
  localparam logic [2:0] kind_rx_dp    = 3'd5;

  // Longest sequence is an RX PLL reset that runs into the CDR timeout
  localparam int wait_limit = 4 * `GT_CDR_TIMEOUT_CYC;

  typedef struct packed {
    logic [2:0] kind;
    logic       cdr_en;
    logic       lock_drop;
    logic       exp_tx_pll;
    logic       exp_rx_pll;
    logic       exp_tx_done;
    logic       exp_rx_done;
    logic       exp_cdr;
  } row_t;

  row_t rows [6];

  logic gtwiz_reset_clk_freerun_in;
  logic gtwiz_reset_all_sync;
  logic gtwiz_reset_tx_pll_and_datapath;
  logic gtwiz_reset_tx_datapath;
  logic gtwiz_reset_rx_pll_and_datapath;
  logic gtwiz_reset_rx_datapath;

  // Transceiver status, driven by the model below
  logic plllock_tx        = 1'b0;
  logic txresetdone       = 1'b0;
  logic userclk_tx_active = 1'b1;
  logic plllock_rx        = 1'b0;
  logic rxcdrlock         = 1'b0;
  logic rxresetdone       = 1'b0;
  logic userclk_rx_active = 1'b1;

  logic pllreset_tx;
  logic gttxreset;
  logic txuserrdy;
  logic pllreset_rx;
  logic rxprogdivreset;
  logic gtrxreset;
  logic rxuserrdy;
  logic reset_tx_done;
  logic reset_rx_done;
  logic rx_cdr_stable;

  // Scenario controls and the sticky flags of the event monitor
  logic        cdr_en         = 1'b0;
  logic        drop_rx_lock   = 1'b0;
  logic        clear_seen     = 1'b0;
  logic        tx_pll_seen    = 1'b0;
  logic        rx_pll_seen    = 1'b0;
  logic        early_gttx     = 1'b0;
  logic        late_userrdy   = 1'b0;
  logic        early_progdiv  = 1'b0;
  logic        prev_gttxreset = 1'b1;
  logic        prev_tx_done   = 1'b0;
  logic        prev_progdiv   = 1'b1;
  int          tx_lock_wait   = 5;
  int          rx_lock_wait   = 5;
  int          cdr_wait       = 5;
  int          tx_done_wait   = 3;
  int          rx_done_wait   = 3;
  int          error_count    = 0;
  int          timeout_count  = 0;
  int unsigned seed_sink;

  // All port names match the testbench signals
  gt_reset_top #(.SHARED_PLL(0)) UUT (.*);

  initial begin
    gtwiz_reset_clk_freerun_in = 1'b0;
    forever #10 gtwiz_reset_clk_freerun_in = ~gtwiz_reset_clk_freerun_in;
  end

  //--------------------------------------------------------------------------
  // Transceiver model
  //--------------------------------------------------------------------------

  // PLL lock drops with the PLL reset and returns 5 to 30 cycles after it
  always @(posedge gtwiz_reset_clk_freerun_in) begin
    if (pllreset_tx !== 1'b0) begin
      plllock_tx   <= 1'b0;
      tx_lock_wait <= 5 + ($urandom % 26);
    end else if (tx_lock_wait != 0) begin
      tx_lock_wait <= tx_lock_wait - 1;
    end else begin
      plllock_tx <= 1'b1;
    end
  end

  always @(posedge gtwiz_reset_clk_freerun_in) begin
    if (pllreset_rx !== 1'b0 || drop_rx_lock) begin
      plllock_rx   <= 1'b0;
      rx_lock_wait <= 5 + ($urandom % 26);
    end else if (rx_lock_wait != 0) begin
      rx_lock_wait <= rx_lock_wait - 1;
    end else begin
      plllock_rx <= 1'b1;
    end
  end

  // The CDR only locks on a running PLL with the RX data path out of reset
  always @(posedge gtwiz_reset_clk_freerun_in) begin
    if (!cdr_en || plllock_rx !== 1'b1 || gtrxreset !== 1'b0) begin
      rxcdrlock <= 1'b0;
      cdr_wait  <= 5 + ($urandom % 26);
    end else if (cdr_wait != 0) begin
      cdr_wait <= cdr_wait - 1;
    end else begin
      rxcdrlock <= 1'b1;
    end
  end

  // Reset done trails user ready by a few cycles on each side
  always @(posedge gtwiz_reset_clk_freerun_in) begin
    if (txuserrdy !== 1'b1) begin
      txresetdone  <= 1'b0;
      tx_done_wait <= 3 + ($urandom % 12);
    end else if (tx_done_wait != 0) begin
      tx_done_wait <= tx_done_wait - 1;
    end else begin
      txresetdone <= 1'b1;
    end
    if (rxuserrdy !== 1'b1) begin
      rxresetdone  <= 1'b0;
      rx_done_wait <= 3 + ($urandom % 12);
    end else if (rx_done_wait != 0) begin
      rx_done_wait <= rx_done_wait - 1;
    end else begin
      rxresetdone <= 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // Event monitor
  //--------------------------------------------------------------------------

  // Records PLL reset activity and ordering faults during one table row
  always @(posedge gtwiz_reset_clk_freerun_in) begin
    prev_gttxreset <= gttxreset;
    prev_tx_done   <= reset_tx_done;
    prev_progdiv   <= rxprogdivreset;
    if (clear_seen) begin
      tx_pll_seen   <= 1'b0;
      rx_pll_seen   <= 1'b0;
      early_gttx    <= 1'b0;
      late_userrdy  <= 1'b0;
      early_progdiv <= 1'b0;
    end else if (!gtwiz_reset_all_sync) begin
      if (pllreset_tx) tx_pll_seen <= 1'b1;
      if (pllreset_rx) rx_pll_seen <= 1'b1;
      if (prev_gttxreset && !gttxreset && !plllock_tx) early_gttx <= 1'b1;
      if (!prev_tx_done && reset_tx_done && !txuserrdy) late_userrdy <= 1'b1;
      if (cdr_en && prev_progdiv && !rxprogdivreset && !rxcdrlock) early_progdiv <= 1'b1;
    end
  end

  //--------------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------------

  task automatic check_value(input string what, input logic got, input logic expected);
    if (got !== expected) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, expected);
      error_count++;
    end
  endtask

  // Polls one done flag until it reaches the wanted level
  task automatic wait_for_done(input logic rx_side, input logic level, input string what);
    int   cycles;
    logic cur;
    cycles = 0;
    cur    = rx_side ? reset_rx_done : reset_tx_done;
    while (cur !== level && cycles < wait_limit) begin
      @(posedge gtwiz_reset_clk_freerun_in);
      cycles++;
      cur = rx_side ? reset_rx_done : reset_tx_done;
    end
    if (cur !== level) begin
      $display("TIMEOUT at %0t ns: %s never happened", $time, what);
      timeout_count++;
    end
  endtask

  // Holds the user requests of one kind high for two cycles
  task automatic pulse_requests(input logic [2:0] kind);
    @(posedge gtwiz_reset_clk_freerun_in);
    gtwiz_reset_tx_pll_and_datapath <= (kind == kind_tx_both);
    gtwiz_reset_tx_datapath         <= (kind == kind_tx_dp) || (kind == kind_tx_both);
    gtwiz_reset_rx_pll_and_datapath <= (kind == kind_rx_pll);
    gtwiz_reset_rx_datapath         <= (kind == kind_rx_dp);
    repeat (2) @(posedge gtwiz_reset_clk_freerun_in);
    gtwiz_reset_tx_pll_and_datapath <= 1'b0;
    gtwiz_reset_tx_datapath         <= 1'b0;
    gtwiz_reset_rx_pll_and_datapath <= 1'b0;
    gtwiz_reset_rx_datapath         <= 1'b0;
  endtask

  task automatic check_row(input int r);
    string tag;
    tag = $sformatf("row %0d", r);
    check_value({tag, " pllreset_tx pulse seen"}, tx_pll_seen, rows[r].exp_tx_pll);
    check_value({tag, " pllreset_rx pulse seen"}, rx_pll_seen, rows[r].exp_rx_pll);
    check_value({tag, " reset_tx_done"}, reset_tx_done, rows[r].exp_tx_done);
    check_value({tag, " reset_rx_done"}, reset_rx_done, rows[r].exp_rx_done);
    check_value({tag, " rx_cdr_stable"}, rx_cdr_stable, rows[r].exp_cdr);
    check_value({tag, " gttxreset released before plllock_tx"}, early_gttx, 1'b0);
    check_value({tag, " reset_tx_done rose before txuserrdy"}, late_userrdy, 1'b0);
    check_value({tag, " rxprogdivreset released before rxcdrlock"}, early_progdiv, 1'b0);
    // Every finished sequence leaves all resets released and user ready high
    check_value({tag, " pllreset_tx"}, pllreset_tx, 1'b0);
    check_value({tag, " gttxreset"}, gttxreset, 1'b0);
    check_value({tag, " txuserrdy"}, txuserrdy, 1'b1);
    check_value({tag, " pllreset_rx"}, pllreset_rx, 1'b0);
    check_value({tag, " rxprogdivreset"}, rxprogdivreset, 1'b0);
    check_value({tag, " gtrxreset"}, gtrxreset, 1'b0);
    check_value({tag, " rxuserrdy"}, rxuserrdy, 1'b1);
  endtask

  //--------------------------------------------------------------------------
  // Scenario table and main sequence
  //--------------------------------------------------------------------------

  initial begin
    gtwiz_reset_all_sync            = 1'b1;
    gtwiz_reset_tx_pll_and_datapath = 1'b0;
    gtwiz_reset_tx_datapath         = 1'b0;
    gtwiz_reset_rx_pll_and_datapath = 1'b0;
    gtwiz_reset_rx_datapath         = 1'b0;

    // kind, cdr_en, lock_drop, tx pll, rx pll, tx done, rx done, cdr stable
    rows[0] = '{kind_power_on, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    rows[1] = '{kind_tx_dp,    1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    rows[2] = '{kind_tx_both,  1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
    rows[3] = '{kind_rx_pll,   1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
    rows[4] = '{kind_rx_dp,    1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    rows[5] = '{kind_none,     1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    cdr_en    = rows[0].cdr_en;
    seed_sink = $urandom(32'h3cb2);

    repeat (5) @(posedge gtwiz_reset_clk_freerun_in);
    gtwiz_reset_all_sync <= 1'b0;

    for (int r = 0; r < 6; r++) begin
      @(posedge gtwiz_reset_clk_freerun_in);
      cdr_en     <= rows[r].cdr_en;
      clear_seen <= 1'b1;
      @(posedge gtwiz_reset_clk_freerun_in);
      clear_seen <= 1'b0;
      case (rows[r].kind)
        // The master sequencer runs TX first, then RX
        kind_power_on: begin
          wait_for_done(1'b0, 1'b1, "reset_tx_done rise after reset");
          wait_for_done(1'b1, 1'b1, "reset_rx_done rise after reset");
        end
        kind_tx_dp, kind_tx_both: begin
          pulse_requests(rows[r].kind);
          wait_for_done(1'b0, 1'b0, "reset_tx_done fall on TX request");
          wait_for_done(1'b0, 1'b1, "reset_tx_done rise after TX request");
        end
        kind_rx_pll, kind_rx_dp: begin
          pulse_requests(rows[r].kind);
          wait_for_done(1'b1, 1'b0, "reset_rx_done fall on RX request");
          wait_for_done(1'b1, 1'b1, "reset_rx_done rise after RX request");
        end
        default: begin
        end
      endcase
      // Lock stays lost until the end of the run
      if (rows[r].lock_drop) begin
        @(posedge gtwiz_reset_clk_freerun_in);
        drop_rx_lock <= 1'b1;
        wait_for_done(1'b1, 1'b0, "reset_rx_done fall on RX lock loss");
      end
      // Synced status lags the raw inputs by a couple of cycles
      repeat (`GT_SETTLE_CYC) @(posedge gtwiz_reset_clk_freerun_in);
      check_row(r);
    end

    $display("Summary: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: gt_reset_top.f
+incdir+.
gt_reset_pkg.sv
status_sync.sv
reset_req_decode.sv
reset_all_seq.sv
tx_reset_seq.sv
rx_reset_seq.sv
gt_reset_top.sv
tb_gt_reset_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the reset sequencer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_gt_reset_top -f gt_reset_top.f

out=$(./obj_dir/Vtb_gt_reset_top)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -qx "All checks passed"
